// ==== Bender.yml ====
package:
  name: bomb_arena

export_include_dirs:
  - .

sources:
  - files:
      - bomberman_pkg.sv
      - compute_player_blocks.sv
      - bomb_slots.sv
      - game_over.sv
      - bomb_arena.sv
  - target: test
    files:
      - tb_bomb_arena.sv

// ==== bomb_arena.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

module bomb_arena (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  place_1,
  input  wire logic                  place_2,
  input  wire bomberman_pkg::pix_x_t player_1_x,
  input  wire bomberman_pkg::pix_y_t player_1_y,
  input  wire bomberman_pkg::pix_x_t player_2_x,
  input  wire bomberman_pkg::pix_y_t player_2_y,
  input  wire logic                  start_over_button,
  output logic                       game_over,
  output bomberman_pkg::slot_mask_t  explode_signal_1,
  output bomberman_pkg::slot_mask_t  explode_signal_2,
  output bomberman_pkg::tile_addr_t  explosion_addr_1 [0:`BOMB_SLOTS-1],
  output bomberman_pkg::tile_addr_t  explosion_addr_2 [0:`BOMB_SLOTS-1]
);

  // Bombs go on the left foot tile
  bomberman_pkg::tile_addr_t place_addr_1;
  bomberman_pkg::tile_addr_t place_addr_2;

  compute_player_blocks u_place_blocks_1 (
    .player_x  (player_1_x),
    .player_y  (player_1_y),
    .blk1_addr (place_addr_1),
    .blk2_addr ()
  );

  compute_player_blocks u_place_blocks_2 (
    .player_x  (player_2_x),
    .player_y  (player_2_y),
    .blk1_addr (place_addr_2),
    .blk2_addr ()
  );

  bomb_slots u_bombs_1 (
    .clk            (clk),
    .rst            (rst),
    .place          (place_1),
    .place_addr     (place_addr_1),
    .game_over      (game_over),
    .explode_signal (explode_signal_1),
    .explosion_addr (explosion_addr_1)
  );

  bomb_slots u_bombs_2 (
    .clk            (clk),
    .rst            (rst),
    .place          (place_2),
    .place_addr     (place_addr_2),
    .game_over      (game_over),
    .explode_signal (explode_signal_2),
    .explosion_addr (explosion_addr_2)
  );

  // Level fed back to both players' slots
  game_over u_game_over (
    .clk               (clk),
    .rst               (rst),
    .explode_signal_1  (explode_signal_1),
    .explode_signal_2  (explode_signal_2),
    .explosion_addr_1  (explosion_addr_1),
    .explosion_addr_2  (explosion_addr_2),
    .player_1_x        (player_1_x),
    .player_1_y        (player_1_y),
    .player_2_x        (player_2_x),
    .player_2_y        (player_2_y),
    .start_over_button (start_over_button),
    .game_over         (game_over)
  );

endmodule

`default_nettype wire

// ==== bomb_slots.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

module bomb_slots (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      place,
  input  wire bomberman_pkg::tile_addr_t place_addr,
  input  wire logic                      game_over,
  output bomberman_pkg::slot_mask_t      explode_signal,
  output bomberman_pkg::tile_addr_t      explosion_addr [0:`BOMB_SLOTS-1]
);

  bomberman_pkg::slot_state_t state [0:`BOMB_SLOTS-1];
  bomberman_pkg::fuse_cnt_t   count [0:`BOMB_SLOTS-1];

  // One-hot grant of the incoming strobe
  bomberman_pkg::slot_mask_t grant;
  logic                      taken;

  // Lowest idle slot wins
  // Strobe dropped when all are busy
  always_comb begin
    grant = '0;
    taken = 1'b0;
    for (int i = 0; i < `BOMB_SLOTS; i++) begin
      if (!taken && state[i] == bomberman_pkg::SLOT_IDLE) begin
        grant[i] = place;
        taken    = 1'b1;
      end
    end
  end

  genvar s;
  generate
    for (s = 0; s < `BOMB_SLOTS; s++) begin : g_slot

      always_ff @(posedge clk) begin
        if (rst) begin
          state[s]          <= bomberman_pkg::SLOT_IDLE;
          count[s]          <= '0;
          explosion_addr[s] <= '0;
        end else if (game_over) begin
          // Drop every live bomb when the round is over
          state[s] <= bomberman_pkg::SLOT_IDLE;
          count[s] <= '0;
        end else begin
          case (state[s])
            bomberman_pkg::SLOT_IDLE: begin
              if (grant[s]) begin
                state[s]          <= bomberman_pkg::SLOT_FUSE;
                count[s]          <= bomberman_pkg::fuse_cnt_t'(`FUSE_CYCLES - 1);
                explosion_addr[s] <= place_addr;
              end
            end
            bomberman_pkg::SLOT_FUSE: begin
              if (count[s] == '0) begin
                state[s] <= bomberman_pkg::SLOT_BLAST;
                count[s] <= bomberman_pkg::fuse_cnt_t'(`EXPLODE_CYCLES - 1);
              end else begin
                count[s] <= count[s] - 1'b1;
              end
            end
            bomberman_pkg::SLOT_BLAST: begin
              // Slot is free again after the last blast cycle
              if (count[s] == '0) begin
                state[s] <= bomberman_pkg::SLOT_IDLE;
              end else begin
                count[s] <= count[s] - 1'b1;
              end
            end
            default: begin
              state[s] <= bomberman_pkg::SLOT_IDLE;
              count[s] <= '0;
            end
          endcase
        end
      end

      assign explode_signal[s] = (state[s] == bomberman_pkg::SLOT_BLAST);

    end
  endgenerate

endmodule

`default_nettype wire

// ==== bomberman_cfg.svh ====
`ifndef BOMBERMAN_CFG_SVH
`define BOMBERMAN_CFG_SVH

// Map geometry in tiles
`define NUM_ROW 11
`define NUM_COL 19

// Tiles are 64 pixels square
`define TILE_SHIFT 6

// Sprite size in pixels
`define SPRITE_W 32
`define SPRITE_H 48

// Bombs a player may have live at the same time
`define BOMB_SLOTS 3

// Cycles spent in fuse before the blast starts
`define FUSE_CYCLES 16

// Cycles the blast stays active
`define EXPLODE_CYCLES 4

// Widths shared by the vector types
`define TILE_ADDR_W 8
`define PIX_X_W 11
`define PIX_Y_W 10
`define FUSE_CNT_W 5

`endif

// ==== bomberman_pkg.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

package bomberman_pkg;

  // Linear tile address, row * NUM_COL + column
  typedef logic [`TILE_ADDR_W-1:0] tile_addr_t;

  // Player pixel coordinates
  typedef logic [`PIX_X_W-1:0] pix_x_t;
  typedef logic [`PIX_Y_W-1:0] pix_y_t;

  // One bit per bomb slot
  typedef logic [`BOMB_SLOTS-1:0] slot_mask_t;

  // Shared counter for fuse and blast
  typedef logic [`FUSE_CNT_W-1:0] fuse_cnt_t;

  typedef enum logic {
    GAME_ACTIVE,
    GAME_OVER
  } game_over_state_t;

  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_FUSE,
    SLOT_BLAST
  } slot_state_t;

endpackage

`default_nettype wire

// ==== compute_player_blocks.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

module compute_player_blocks (
  input  wire bomberman_pkg::pix_x_t player_x,
  input  wire bomberman_pkg::pix_y_t player_y,
  output bomberman_pkg::tile_addr_t  blk1_addr,
  output bomberman_pkg::tile_addr_t  blk2_addr
);

  // Feet sit on the bottom row of the sprite
  bomberman_pkg::pix_y_t foot_y;
  bomberman_pkg::pix_x_t right_x;

  bomberman_pkg::pix_y_t foot_row;
  bomberman_pkg::pix_x_t left_col;
  bomberman_pkg::pix_x_t right_col;

  logic [15:0] row_base;

  assign foot_y  = player_y + bomberman_pkg::pix_y_t'(`SPRITE_H - 1);
  assign right_x = player_x + bomberman_pkg::pix_x_t'(`SPRITE_W - 1);

  // Pixel to tile coordinates
  assign foot_row  = foot_y >> `TILE_SHIFT;
  assign left_col  = player_x >> `TILE_SHIFT;
  assign right_col = right_x >> `TILE_SHIFT;

  assign row_base = 16'(foot_row) * 16'(`NUM_COL);

  // Truncated to the 8-bit map address
  assign blk1_addr = bomberman_pkg::tile_addr_t'(row_base + 16'(left_col));
  assign blk2_addr = bomberman_pkg::tile_addr_t'(row_base + 16'(right_col));

endmodule

`default_nettype wire

// ==== game_over.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

module game_over (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire bomberman_pkg::slot_mask_t explode_signal_1,
  input  wire bomberman_pkg::slot_mask_t explode_signal_2,
  input  wire bomberman_pkg::tile_addr_t explosion_addr_1 [0:`BOMB_SLOTS-1],
  input  wire bomberman_pkg::tile_addr_t explosion_addr_2 [0:`BOMB_SLOTS-1],
  input  wire bomberman_pkg::pix_x_t     player_1_x,
  input  wire bomberman_pkg::pix_y_t     player_1_y,
  input  wire bomberman_pkg::pix_x_t     player_2_x,
  input  wire bomberman_pkg::pix_y_t     player_2_y,
  input  wire logic                      start_over_button,
  output logic                           game_over
);

  bomberman_pkg::game_over_state_t st;
  bomberman_pkg::game_over_state_t nst;

  bomberman_pkg::tile_addr_t p1_blk1, p1_blk2;
  bomberman_pkg::tile_addr_t p2_blk1, p2_blk2;

  logic hit;

  compute_player_blocks u_blocks_1 (
    .player_x  (player_1_x),
    .player_y  (player_1_y),
    .blk1_addr (p1_blk1),
    .blk2_addr (p1_blk2)
  );

  compute_player_blocks u_blocks_2 (
    .player_x  (player_2_x),
    .player_y  (player_2_y),
    .blk1_addr (p2_blk1),
    .blk2_addr (p2_blk2)
  );

  // Cross pattern of each blasting slot, neighbours wrap modulo 256
  function automatic logic tile_hit(
    input bomberman_pkg::tile_addr_t blk,
    input bomberman_pkg::tile_addr_t bomb [0:`BOMB_SLOTS-1],
    input bomberman_pkg::slot_mask_t blasting
  );
    bomberman_pkg::tile_addr_t up, down, left, right;
    logic                      found;
    found = 1'b0;
    for (int i = 0; i < `BOMB_SLOTS; i++) begin
      up    = bomb[i] - bomberman_pkg::tile_addr_t'(`NUM_COL);
      down  = bomb[i] + bomberman_pkg::tile_addr_t'(`NUM_COL);
      left  = bomb[i] - 1'b1;
      right = bomb[i] + 1'b1;
      if (blasting[i] && (blk == bomb[i] || blk == up || blk == down ||
                          blk == left || blk == right)) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Every foot tile against both bomb sets
  assign hit = tile_hit(p1_blk1, explosion_addr_1, explode_signal_1) ||
               tile_hit(p1_blk2, explosion_addr_1, explode_signal_1) ||
               tile_hit(p1_blk1, explosion_addr_2, explode_signal_2) ||
               tile_hit(p1_blk2, explosion_addr_2, explode_signal_2) ||
               tile_hit(p2_blk1, explosion_addr_1, explode_signal_1) ||
               tile_hit(p2_blk2, explosion_addr_1, explode_signal_1) ||
               tile_hit(p2_blk1, explosion_addr_2, explode_signal_2) ||
               tile_hit(p2_blk2, explosion_addr_2, explode_signal_2);

  always_ff @(posedge clk) begin
    if (rst) begin
      st <= bomberman_pkg::GAME_ACTIVE;
    end else begin
      st <= nst;
    end
  end

  always_comb begin
    nst = st;
    case (st)
      bomberman_pkg::GAME_ACTIVE: if (hit) nst = bomberman_pkg::GAME_OVER;
      bomberman_pkg::GAME_OVER:   if (start_over_button) nst = bomberman_pkg::GAME_ACTIVE;
      default:                    nst = bomberman_pkg::GAME_ACTIVE;
    endcase
  end

  assign game_over = (st == bomberman_pkg::GAME_OVER);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
bomberman_pkg.sv
compute_player_blocks.sv
bomb_slots.sv
game_over.sv
bomb_arena.sv
tb_bomb_arena.sv

// ==== tb_bomb_arena.sv ====
`default_nettype none

`include "bomberman_cfg.svh"

module tb_bomb_arena;

  localparam int WAIT_LIMIT = 64;

  logic                      clk;
  logic                      rst;
  logic                      place_1;
  logic                      place_2;
  logic                      start_over_button;
  logic                      game_over;
  bomberman_pkg::pix_x_t     player_1_x;
  bomberman_pkg::pix_x_t     player_2_x;
  bomberman_pkg::pix_y_t     player_1_y;
  bomberman_pkg::pix_y_t     player_2_y;
  bomberman_pkg::slot_mask_t explode_signal_1;
  bomberman_pkg::slot_mask_t explode_signal_2;
  bomberman_pkg::tile_addr_t explosion_addr_1 [0:`BOMB_SLOTS-1];
  bomberman_pkg::tile_addr_t explosion_addr_2 [0:`BOMB_SLOTS-1];

  // Cycle model of both players' bomb slots
  bit                        m_busy  [0:1][0:`BOMB_SLOTS-1];
  int                        m_start [0:1][0:`BOMB_SLOTS-1];
  bomberman_pkg::tile_addr_t m_addr  [0:1][0:`BOMB_SLOTS-1];
  logic                      m_go;
  int                        cyc;
  int                        errors;
  int                        checks;
  integer                    seed;

  bomb_arena DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic bomberman_pkg::tile_addr_t foot_tile(input bomberman_pkg::pix_x_t x,
                                                         input bomberman_pkg::pix_y_t y,
                                                         input bit right);
    int row;
    int col;
    row = (int'(y) + `SPRITE_H - 1) >> `TILE_SHIFT;
    col = (int'(x) + (right ? `SPRITE_W - 1 : 0)) >> `TILE_SHIFT;
    return bomberman_pkg::tile_addr_t'((row * `NUM_COL + col) % 256);
  endfunction

  // Own tile plus the four neighbours, all modulo 256
  function automatic bit cross_hit(input bomberman_pkg::tile_addr_t bomb,
                                   input bomberman_pkg::tile_addr_t foot);
    bomberman_pkg::tile_addr_t d;
    d = foot - bomb;
    return d == 8'd0 || d == 8'd1 || d == 8'd255 || d == 8'(`NUM_COL) ||
           d == 8'(256 - `NUM_COL);
  endfunction

  function automatic bomberman_pkg::tile_addr_t player_foot(input int p, input bit right);
    return (p == 0) ? foot_tile(player_1_x, player_1_y, right)
                    : foot_tile(player_2_x, player_2_y, right);
  endfunction

  function automatic bomberman_pkg::slot_mask_t model_blast(input int p);
    bomberman_pkg::slot_mask_t m;
    int                        age;
    m = '0;
    for (int s = 0; s < `BOMB_SLOTS; s++) begin
      age = cyc - m_start[p][s];
      if (m_busy[p][s] && age > `FUSE_CYCLES && age <= `FUSE_CYCLES + `EXPLODE_CYCLES) begin
        m[s] = 1'b1;
      end
    end
    return m;
  endfunction

  function automatic bomberman_pkg::slot_mask_t blast_of(input int p);
    return (p == 1) ? explode_signal_1 : explode_signal_2;
  endfunction

  task automatic check_mask(input string name, input bomberman_pkg::slot_mask_t got,
                            input bomberman_pkg::slot_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input bomberman_pkg::tile_addr_t got,
                            input bomberman_pkg::tile_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Pre-edge outputs against the model, then the model steps
  always @(posedge clk) begin : compare_model
    bomberman_pkg::slot_mask_t exp_mask [0:1];
    logic                      hit;
    logic                      took;
    if (rst) begin
      for (int p = 0; p < 2; p++) begin
        for (int s = 0; s < `BOMB_SLOTS; s++) begin
          m_busy[p][s] = 1'b0;
          m_addr[p][s] = '0;
        end
      end
      m_go = 1'b0;
    end else begin
      exp_mask[0] = model_blast(0);
      exp_mask[1] = model_blast(1);
      check_mask("explode_signal_1", explode_signal_1, exp_mask[0]);
      check_mask("explode_signal_2", explode_signal_2, exp_mask[1]);
      for (int s = 0; s < `BOMB_SLOTS; s++) begin
        check_addr("explosion_addr_1", explosion_addr_1[s], m_addr[0][s]);
        check_addr("explosion_addr_2", explosion_addr_2[s], m_addr[1][s]);
      end
      check_flag("game_over", game_over, m_go);
      hit = 1'b0;
      for (int p = 0; p < 2; p++) begin
        took = 1'b0;
        for (int s = 0; s < `BOMB_SLOTS; s++) begin
          for (int f = 0; f < 4; f++) begin
            hit |= exp_mask[p][s] && cross_hit(m_addr[p][s], player_foot(f / 2, f % 2));
          end
          if (m_go) begin
            m_busy[p][s] = 1'b0;
          end else if ((p == 0 ? place_1 : place_2) && !took &&
                       (!m_busy[p][s] ||
                        cyc - m_start[p][s] > `FUSE_CYCLES + `EXPLODE_CYCLES)) begin
            m_busy[p][s]  = 1'b1;
            m_start[p][s] = cyc;
            m_addr[p][s]  = player_foot(p, 1'b0);
            took          = 1'b1;
          end
        end
      end
      m_go = m_go ? !start_over_button : hit;
    end
    cyc++;
  end

  task automatic end_run();
    $display("Checks %0d, mismatches %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic timeout(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    end_run();
  endtask

  task automatic wait_mask(input int p, input bomberman_pkg::slot_mask_t mask, output int n);
    n = 0;
    while ((blast_of(p) & mask) != mask) begin
      if (n == WAIT_LIMIT) timeout("a blast to start");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_quiet(input int p, output logic seen, output int n);
    n    = 0;
    seen = game_over;
    while (blast_of(p) != '0) begin
      if (n == WAIT_LIMIT) timeout("the blast to end");
      @(negedge clk);
      n++;
      seen |= game_over;
    end
  endtask

  task automatic wait_level(input logic level, output int n);
    n = 0;
    while (game_over !== level) begin
      if (n == WAIT_LIMIT) timeout("game over to change");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic set_pos(input int p, input int col, input int row);
    if (p == 1) begin
      player_1_x = bomberman_pkg::pix_x_t'(col * 64 + 8);
      player_1_y = bomberman_pkg::pix_y_t'(row * 64 + 8);
    end else begin
      player_2_x = bomberman_pkg::pix_x_t'(col * 64 + 8);
      player_2_y = bomberman_pkg::pix_y_t'(row * 64 + 8);
    end
  endtask

  task automatic strobe(input int p);
    @(negedge clk);
    place_1 = (p == 1);
    place_2 = (p == 2);
    @(negedge clk);
    place_1 = 1'b0;
    place_2 = 1'b0;
  endtask

  task automatic restart();
    @(negedge clk);
    start_over_button = 1'b1;
    @(negedge clk);
    start_over_button = 1'b0;
    check_flag("cleared by start over", game_over, 1'b0);
  endtask

  // Player 1 bombs a tile and walks off, player 2 stays put
  task automatic run_bomb(input int col, input int row, input logic exp_hit);
    logic seen;
    int   n;
    set_pos(1, col, row);
    strobe(1);
    set_pos(1, 17, 9);
    wait_mask(1, 3'b001, n);
    wait_quiet(1, seen, n);
    check_flag("game over from blast", seen, exp_hit);
    if (seen) restart();
  endtask

  task automatic report(input int num, input string name, input int err0);
    if (errors == err0) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d mismatches", num, name, errors - err0);
    end
  endtask

  initial begin
    int                        err0;
    int                        n;
    logic                      seen;
    logic                      exp_hit;
    bomberman_pkg::tile_addr_t tile;
    seed              = 32'h137e_1ed6;
    rst               = 1'b1;
    place_1           = 1'b0;
    place_2           = 1'b0;
    start_over_button = 1'b0;
    errors            = 0;
    checks            = 0;
    cyc               = 0;
    set_pos(1, 2, 2);
    set_pos(2, 15, 8);
    repeat (8) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    tile = foot_tile(player_1_x, player_1_y, 1'b0);
    strobe(1);
    set_pos(1, 10, 8);
    check_addr("bomb tile", explosion_addr_1[0], tile);
    wait_mask(1, 3'b001, n);
    check_flag("blast after the fuse", logic'(n == `FUSE_CYCLES), 1'b1);
    wait_quiet(1, seen, n);
    check_flag("blast length", logic'(n == `EXPLODE_CYCLES), 1'b1);
    report(1, "fuse and blast timing", err0);

    err0 = errors;
    set_pos(1, 5, 3);
    tile = foot_tile(player_1_x, player_1_y, 1'b0);
    strobe(1);
    wait_level(1'b1, n);
    check_flag("self hit after blast start", logic'(n == `FUSE_CYCLES + 1), 1'b1);
    restart();
    for (int i = 0; i < 8; i++) begin
      player_2_x = bomberman_pkg::pix_x_t'(192 + {$random(seed)} % 320);
      player_2_y = bomberman_pkg::pix_y_t'(64 + {$random(seed)} % 320);
      exp_hit    = cross_hit(tile, player_foot(1, 1'b0)) || cross_hit(tile, player_foot(1, 1'b1));
      run_bomb(5, 3, exp_hit);
    end
    report(2, "self hit and foot mapping", err0);

    err0 = errors;
    set_pos(2, 5, 2);
    run_bomb(5, 3, 1'b1);
    set_pos(2, 5, 4);
    run_bomb(5, 3, 1'b1);
    set_pos(2, 4, 3);
    run_bomb(5, 3, 1'b1);
    set_pos(2, 6, 3);
    run_bomb(5, 3, 1'b1);
    set_pos(2, 6, 2);
    run_bomb(5, 3, 1'b0);
    report(3, "cross coverage", err0);

    // Four strobes in a row from four different tiles
    err0 = errors;
    set_pos(2, 12, 2);
    set_pos(1, 4, 8);
    @(negedge clk);
    place_1 = 1'b1;
    for (int i = 1; i < 4; i++) begin
      @(negedge clk);
      set_pos(1, 4 + 2 * i, 8);
    end
    @(negedge clk);
    place_1 = 1'b0;
    set_pos(1, 17, 9);
    wait_mask(1, 3'b111, n);
    wait_quiet(1, seen, n);
    check_flag("no game over", seen, 1'b0);
    set_pos(1, 2, 2);
    tile = foot_tile(player_1_x, player_1_y, 1'b0);
    strobe(1);
    set_pos(1, 17, 9);
    check_addr("slot 0 reused", explosion_addr_1[0], tile);
    wait_mask(1, 3'b001, n);
    wait_quiet(1, seen, n);
    report(4, "slot capacity", err0);

    err0 = errors;
    set_pos(1, 5, 3);
    strobe(1);
    wait_level(1'b1, n);
    place_1 = 1'b1;
    place_2 = 1'b1;
    repeat (2) @(negedge clk);
    place_1 = 1'b0;
    place_2 = 1'b0;
    check_mask("slots idle in game over", explode_signal_1 | explode_signal_2, '0);
    restart();
    for (int i = 0; i < `FUSE_CYCLES + `EXPLODE_CYCLES + 2; i++) begin
      @(negedge clk);
      check_mask("ignored strobes stay idle", explode_signal_1 | explode_signal_2, '0);
    end
    report(5, "restart", err0);

    err0 = errors;
    set_pos(1, 10, 6);
    set_pos(2, 10, 5);
    strobe(2);
    set_pos(2, 17, 1);
    wait_level(1'b1, n);
    check_flag("cross-player hit timing", logic'(n == `FUSE_CYCLES + 1), 1'b1);
    restart();
    report(6, "cross-player hit", err0);

    end_run();
  end

endmodule

`default_nettype wire
